// ==== src/audioPkg.sv ====
`default_nettype none

package audioPkg;

    typedef enum logic [2:0] {
        MENU   = 3'd0,
        WIN    = 3'd1,
        LOSE   = 3'd2,
        STAGE1 = 3'd3
    } gameStateT;

    typedef enum logic [3:0] {
        C3, D3, E3, F3, G3, A3, B3,
        C4, D4, E4, F4, G4, A4, B4,
        NOTE_SILENT
    } noteT;

    localparam int unsigned CLK_HZ = 50_000_000;
    localparam int DIV_W = 22;

    // pitch per note code, silent and spare codes divide down to 1
    localparam int unsigned noteFreqHz [16] = '{
        262, 293, 330, 349, 392, 440, 494,
        524, 588, 660, 698, 784, 880, 988,
        CLK_HZ, CLK_HZ
    };

    // half-period length in clk cycles
    localparam logic [DIV_W-1:0] noteDivisor [16] = '{
        DIV_W'(CLK_HZ / noteFreqHz[0]),
        DIV_W'(CLK_HZ / noteFreqHz[1]),
        DIV_W'(CLK_HZ / noteFreqHz[2]),
        DIV_W'(CLK_HZ / noteFreqHz[3]),
        DIV_W'(CLK_HZ / noteFreqHz[4]),
        DIV_W'(CLK_HZ / noteFreqHz[5]),
        DIV_W'(CLK_HZ / noteFreqHz[6]),
        DIV_W'(CLK_HZ / noteFreqHz[7]),
        DIV_W'(CLK_HZ / noteFreqHz[8]),
        DIV_W'(CLK_HZ / noteFreqHz[9]),
        DIV_W'(CLK_HZ / noteFreqHz[10]),
        DIV_W'(CLK_HZ / noteFreqHz[11]),
        DIV_W'(CLK_HZ / noteFreqHz[12]),
        DIV_W'(CLK_HZ / noteFreqHz[13]),
        DIV_W'(CLK_HZ / noteFreqHz[14]),
        DIV_W'(CLK_HZ / noteFreqHz[15])
    };

    localparam int BEAT_W      = 12;
    localparam int MENU_LEN    = 256;  // beats in the menu loop
    localparam int EFFECT_STEP = 8;    // one jingle phrase
    localparam int EFFECT_MAX  = 48;
    localparam int VOLUME_W    = 3;
    localparam int SAMPLE_W    = 16;
    localparam int FRAME_W     = 9;    // 512 clk per stereo frame
    localparam int SLOT_LSB    = 4;    // 16 clk per serial bit

    function automatic logic [SAMPLE_W-1:0] highAmp(input logic [VOLUME_W-1:0] volume);
        case (volume)
            3'd1:    return 16'hF800;
            3'd2:    return 16'hF000;
            3'd3:    return 16'hE000;
            3'd4:    return 16'hC000;
            default: return 16'hA000;
        endcase
    endfunction

    function automatic logic [SAMPLE_W-1:0] lowAmp(input logic [VOLUME_W-1:0] volume);
        case (volume)
            3'd1:    return 16'h0800;
            3'd2:    return 16'h1000;
            3'd3:    return 16'h2000;
            3'd4:    return 16'h4000;
            default: return 16'h6000;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/menuTheme.sv ====
`timescale 1ns/1ps
`default_nettype none

module menuTheme
    import audioPkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic play,
    input  wire logic beatTick,
    output noteT      note
);

    logic [BEAT_W-1:0] beatIdx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beatIdx <= '0;
        end else if (!play) begin
            beatIdx <= '0;   // theme restarts on next entry
        end else if (beatTick) begin
            if (beatIdx == BEAT_W'(MENU_LEN - 1)) begin
                beatIdx <= '0;
            end else begin
                beatIdx <= beatIdx + 1'b1;
            end
        end
    end

    // score as runs of beats, phrase ends fall to the default rest
    always_comb begin
        case (beatIdx) inside
            [12'd0:12'd30]:    note = C3;
            [12'd32:12'd46]:   note = G3;
            [12'd48:12'd52]:   note = F3;
            [12'd53:12'd57]:   note = E3;
            [12'd58:12'd62]:   note = D3;

            [12'd64:12'd94]:   note = C4;
            [12'd96:12'd110]:  note = G3;
            [12'd112:12'd116]: note = F3;
            [12'd117:12'd121]: note = E3;
            [12'd122:12'd126]: note = D3;

            [12'd128:12'd158]: note = C4;
            [12'd160:12'd174]: note = G3;
            [12'd176:12'd180]: note = F3;
            [12'd181:12'd185]: note = E3;
            [12'd186:12'd190]: note = F3;   // turn back up before the long D

            [12'd192:12'd254]: note = D3;
            default:           note = NOTE_SILENT;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/collisionEffect.sv ====
`timescale 1ns/1ps
`default_nettype none

module collisionEffect
    import audioPkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic play,
    input  wire logic beatTick,
    input  wire logic collision,
    output noteT      note
);

    logic [BEAT_W-1:0] budget;    // beats the jingle may still reach
    logic [BEAT_W-1:0] beatIdx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            budget <= '0;
        end else if (collision) begin
            if (budget < BEAT_W'(EFFECT_MAX)) begin
                budget <= budget + BEAT_W'(EFFECT_STEP);
            end else begin
                budget <= BEAT_W'(EFFECT_STEP);   // saturated, start over
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beatIdx <= '0;
        end else if (beatTick) begin
            if (beatIdx > budget + BEAT_W'(EFFECT_STEP)) begin
                beatIdx <= '0;   // budget fell behind the index
            end else if (play && (beatIdx + 1'b1 < budget)) begin
                beatIdx <= beatIdx + 1'b1;
            end
        end
    end

    // three phrases of two bars, rests on every eighth beat
    always_comb begin
        case (beatIdx) inside
            [12'd1:12'd6],   [12'd8:12'd14]:  note = E4;
            [12'd16:12'd22], [12'd24:12'd30]: note = C4;
            [12'd32:12'd38], [12'd40:12'd46]: note = G4;
            default:                          note = NOTE_SILENT;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/musicSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module musicSequencer
    import audioPkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire gameStateT gameState,
    input  wire logic      beatTick,
    input  wire logic      collision,
    output noteT           currentNote
);

    logic isMenu;
    noteT menuNote;
    noteT effectNote;

    // the only place the game state is decoded
    assign isMenu = (gameState == MENU);

    menuTheme uMenu (
        .clk      (clk),
        .rst      (rst),
        .play     (isMenu),
        .beatTick (beatTick),
        .note     (menuNote)
    );

    collisionEffect uEffect (
        .clk       (clk),
        .rst       (rst),
        .play      (!isMenu),   // jingle runs in every non-menu state
        .beatTick  (beatTick),
        .collision (collision),
        .note      (effectNote)
    );

    assign currentNote = isMenu ? menuNote : effectNote;

endmodule

`default_nettype wire

// ==== src/toneGenerator.sv ====
`timescale 1ns/1ps
`default_nettype none

module toneGenerator
    import audioPkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire noteT                note,
    input  wire logic [VOLUME_W-1:0] volume,
    output logic      [SAMPLE_W-1:0] sample
);

    logic [DIV_W-1:0] halfCnt;
    logic [DIV_W-1:0] divisor;
    logic             phase;       // low half of the square wave is high amplitude
    noteT             prevNote;
    logic             noteChanged;

    assign divisor     = noteDivisor[note];
    assign noteChanged = (note != prevNote);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prevNote <= NOTE_SILENT;
        end else begin
            prevNote <= note;
        end
    end

    // half period lasts divisor + 1 cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            halfCnt <= '0;
            phase   <= 1'b0;
        end else if (noteChanged) begin
            halfCnt <= '0;   // new note starts on a clean edge
            phase   <= 1'b0;
        end else if (halfCnt == divisor) begin
            halfCnt <= '0;
            phase   <= ~phase;
        end else begin
            halfCnt <= halfCnt + 1'b1;
        end
    end

    always_comb begin
        if (note == NOTE_SILENT) begin
            sample = '0;
        end else if (!phase) begin
            sample = highAmp(volume);
        end else begin
            sample = lowAmp(volume);
        end
    end

endmodule

`default_nettype wire

// ==== src/i2sSerializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2sSerializer
    import audioPkg::*;
(
    input  wire logic [SAMPLE_W-1:0] sample,
    input  wire logic                clk,
    input  wire logic                rst,
    output logic                     audioMclk,
    output logic                     audioLrck,
    output logic                     audioSdin
);

    logic [FRAME_W-1:0]          frameCnt;
    logic [SAMPLE_W-1:0]         heldSample;
    logic                        rightLsb;   // last frame's right word bit 0
    logic [FRAME_W-SLOT_LSB-1:0] slot;       // 32 serial bit slots per frame
    logic [3:0]                  bitSel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frameCnt <= '0;
        end else begin
            frameCnt <= frameCnt + 1'b1;
        end
    end

    // capture once per frame, on the 511 to 0 wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            heldSample <= '0;
            rightLsb   <= 1'b0;
        end else if (&frameCnt) begin
            heldSample <= sample;
            rightLsb   <= heldSample[0];
        end
    end

    assign audioMclk = frameCnt[1];           // clk / 4
    assign audioLrck = frameCnt[FRAME_W-1];   // high during the right word
    assign slot      = frameCnt[FRAME_W-1:SLOT_LSB];

    // Word bits trail the word clock by one slot. Slot 0 carries the last frame's
    // right bit 0, slots 1..16 left bits 15..0 and slots 17..31 right bits 15..1.
    // Both words hold the same sample, so the bit index is just -slot mod 16.
    assign bitSel    = 4'(5'd0 - slot);
    assign audioSdin = (slot == '0) ? rightLsb : heldSample[bitSel];

endmodule

`default_nettype wire

// ==== src/gameMusicTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module gameMusicTop
    import audioPkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire gameStateT           gameState,
    input  wire logic                beatTick,   // one beat, single clk pulse
    input  wire logic                collision,
    input  wire logic [VOLUME_W-1:0] volume,
    output logic                     audioMclk,
    output logic                     audioLrck,
    output logic                     audioSdin
);

    noteT                currentNote;
    logic [SAMPLE_W-1:0] sample;

    musicSequencer uSequencer (
        .clk         (clk),
        .rst         (rst),
        .gameState   (gameState),
        .beatTick    (beatTick),
        .collision   (collision),
        .currentNote (currentNote)
    );

    toneGenerator uTone (
        .clk    (clk),
        .rst    (rst),
        .note   (currentNote),
        .volume (volume),
        .sample (sample)
    );

    // mono sample goes out on both channels
    i2sSerializer uSerializer (
        .clk       (clk),
        .rst       (rst),
        .sample    (sample),
        .audioMclk (audioMclk),
        .audioLrck (audioLrck),
        .audioSdin (audioSdin)
    );

endmodule

`default_nettype wire

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;   // 4 ns period

endmodule

`default_nettype wire

// ==== testbench/gameMusicTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gameMusicTb
    import audioPkg::*;
();

    localparam int CLK_RATE       = 50_000_000;
    localparam int FRAME_CYCLES   = 512;
    // the three pitch runs need up to ~750 frames each, jingle tests ~100k cycles
    localparam int TIMEOUT_CYCLES = 4_000_000;

    logic       clk;
    logic       rst;
    gameStateT  gameState;
    logic       beatTick;
    logic       collision;
    logic [2:0] volume;
    logic       audioMclk;
    logic       audioLrck;
    logic       audioSdin;

    int         errors = 0;
    int         cycleCount = 0;
    int         seed = 32'he721_e508;
    int         budget;      // reference model of the jingle
    int         effIdx;
    int         menuIdx;
    gameStateT  stateNow;
    logic [2:0] curVolume;

    // frame monitor state
    int          slotPos = -1;
    int          slotNo;
    logic        lastLrck = 1'b0;
    logic        haveFrame = 1'b0;
    logic [15:0] wordL;
    logic [15:0] wordR;
    logic [15:0] frameLeft;
    logic [15:0] frameRight;
    int          frameCount = 0;

    tbClock uClock (.clk(clk));

    gameMusicTop DUT (
        .clk       (clk),
        .rst       (rst),
        .gameState (gameState),
        .beatTick  (beatTick),
        .collision (collision),
        .volume    (volume),
        .audioMclk (audioMclk),
        .audioLrck (audioLrck),
        .audioSdin (audioSdin)
    );

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles, %0d errors", cycleCount, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Follows every frame from the lrck fall, sampling mid-slot. The right word's
    // LSB arrives in slot 0 of the next frame, so a frame is published there.
    always @(negedge clk) begin
        if (lastLrck && !audioLrck) begin
            slotPos = 0;
        end else if (slotPos >= 0) begin
            slotPos = slotPos + 1;
        end
        lastLrck = audioLrck;
        if (slotPos >= 0 && slotPos % 16 == 8) begin
            slotNo = slotPos / 16;
            if (slotNo == 0) begin
                if (haveFrame) begin
                    frameLeft  = wordL;
                    frameRight = {wordR[15:1], audioSdin};
                    frameCount = frameCount + 1;
                end
                haveFrame = 1'b1;
            end else if (slotNo <= 16) begin
                wordL[16-slotNo] = audioSdin;   // MSB first
            end else begin
                wordR[32-slotNo] = audioSdin;
            end
        end
    end

    function automatic logic [15:0] expectHigh(input logic [2:0] v);
        case (v)
            3'd1:    return 16'hF800;
            3'd2:    return 16'hF000;
            3'd3:    return 16'hE000;
            3'd4:    return 16'hC000;
            default: return 16'hA000;
        endcase
    endfunction

    function automatic logic [15:0] expectLow(input logic [2:0] v);
        case (v)
            3'd1:    return 16'h0800;
            3'd2:    return 16'h1000;
            3'd3:    return 16'h2000;
            3'd4:    return 16'h4000;
            default: return 16'h6000;
        endcase
    endfunction

    function automatic bit jingleSounds(input int idx);
        return (idx >= 1 && idx <= 46 && idx % 8 != 7);
    endfunction

    // only the opening runs of the theme are measured
    function automatic int menuFreq(input int idx);
        if (idx <= 30) begin
            return 262;
        end
        return 392;
    endfunction

    task automatic reportValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors = errors + 1;
        $display("ERR %s: got %0h expected %0h", name, got, exp);
    endtask

    task automatic skipFrames(input int n);
        int target;
        target = frameCount + n;
        wait (frameCount >= target);
    endtask

    task automatic decodeFrame(output logic [15:0] left, output logic [15:0] right);
        skipFrames(1);
        left  = frameLeft;
        right = frameRight;
    endtask

    task automatic checkFrame(input bit sounding);
        logic [15:0] left;
        logic [15:0] right;
        decodeFrame(left, right);
        if (left !== right) reportValue("audioSdin right word", right, left);
        if (!sounding) begin
            if (left !== 16'h0000) reportValue("audioSdin left word", left, 16'h0000);
        end else if (left !== expectHigh(curVolume) && left !== expectLow(curVolume)) begin
            errors = errors + 1;
            $display("ERR audioSdin left word: got %0h expected %0h or %0h",
                     left, expectHigh(curVolume), expectLow(curVolume));
        end
    endtask

    task automatic setState(input gameStateT s);
        @(negedge clk);
        gameState = s;
        stateNow  = s;
        if (s != MENU) menuIdx = 0;   // theme held at its start
    endtask

    task automatic pulseCollision();
        @(negedge clk);
        collision = 1'b1;
        budget    = (budget < 48) ? budget + 8 : 8;
        @(negedge clk);
        collision = 1'b0;
    endtask

    task automatic pulseBeat();
        @(negedge clk);
        beatTick = 1'b1;
        if (stateNow == MENU) menuIdx = (menuIdx + 1) % 256;
        if (effIdx > budget + 8) begin
            effIdx = 0;
        end else if (stateNow != MENU && effIdx + 1 < budget) begin
            effIdx = effIdx + 1;
        end
        @(negedge clk);
        beatTick = 1'b0;
    endtask

    task automatic runBeats(input int n);
        repeat (n) begin
            pulseBeat();
            skipFrames(2);
            checkFrame(jingleSounds(effIdx));
        end
    endtask

    task automatic cyclesToRise(input bit useLrck, output int n);
        logic prev;
        logic cur;
        cur = useLrck ? audioLrck : audioMclk;
        n = 0;
        do begin
            prev = cur;
            @(negedge clk);
            n = n + 1;
            cur = useLrck ? audioLrck : audioMclk;
        end while (!(cur && !prev));
    endtask

    task automatic checkVolume(input logic [2:0] v);
        @(negedge clk);
        volume    = v;
        curVolume = v;
        skipFrames(2);
        checkFrame(1'b1);
        checkFrame(1'b1);
    endtask

    // frames between two phase changes of the decoded square wave
    task automatic measurePitch(input int hz);
        int          expFrames;
        int          count;
        logic [15:0] left;
        logic [15:0] right;
        logic [15:0] level;
        expFrames = (CLK_RATE / hz + 1) / FRAME_CYCLES;
        skipFrames(2);
        decodeFrame(level, right);
        for (int edgeNo = 0; edgeNo < 2; edgeNo++) begin
            count = 0;
            do begin
                decodeFrame(left, right);
                count = count + 1;
            end while (left == level && count <= 2 * expFrames);
            if (left == level) begin
                errors = errors + 1;
                $display("no phase change seen within %0d frames at %0d Hz", count, hz);
                return;
            end
            level = left;
        end
        if (count < expFrames - 1 || count > expFrames + 1) begin
            reportValue("frames per half period", count, expFrames);
        end
    endtask

    task automatic resetState();
        repeat (10) begin
            @(negedge clk);
            if (audioMclk !== 1'b0) reportValue("audioMclk", audioMclk, 0);
            if (audioLrck !== 1'b0) reportValue("audioLrck", audioLrck, 0);
            if (audioSdin !== 1'b0) reportValue("audioSdin", audioSdin, 0);
        end
        rst = 1'b0;
        @(negedge clk);
        if (audioMclk !== 1'b0) reportValue("audioMclk", audioMclk, 0);
        if (audioLrck !== 1'b0) reportValue("audioLrck", audioLrck, 0);
        if (audioSdin !== 1'b0) reportValue("audioSdin", audioSdin, 0);
        checkFrame(1'b0);
        checkFrame(1'b0);
    endtask

    task automatic frameFormat();
        int n;
        setState(MENU);
        cyclesToRise(1'b1, n);
        cyclesToRise(1'b1, n);
        if (n != FRAME_CYCLES) reportValue("audioLrck period", n, FRAME_CYCLES);
        cyclesToRise(1'b0, n);
        cyclesToRise(1'b0, n);
        if (n != 4) reportValue("audioMclk period", n, 4);
        for (int k = 1; k <= 5; k++) checkVolume(3'(k));
        repeat (4) checkVolume(3'($random(seed)));
    endtask

    task automatic jingleStart();
        setState(STAGE1);
        pulseCollision();
        runBeats(10);   // settles silent on beat 7
    endtask

    task automatic jingleExtend();
        pulseCollision();
        runBeats(10);
        repeat (4) pulseCollision();   // budget up to 48
        runBeats(33);
        pulseCollision();              // past the limit, back to 8
        runBeats(9);
    endtask

    task automatic menuPitch();
        setState(MENU);
        measurePitch(menuFreq(menuIdx));
        repeat (32) pulseBeat();
        measurePitch(menuFreq(menuIdx));
    endtask

    task automatic menuRestart();
        setState(STAGE1);
        skipFrames(1);
        setState(MENU);
        measurePitch(menuFreq(menuIdx));
    endtask

    initial begin
        rst       = 1'b1;
        gameState = LOSE;
        beatTick  = 1'b0;
        collision = 1'b0;
        volume    = 3'd3;
        curVolume = 3'd3;
        stateNow  = LOSE;
        budget    = 0;
        effIdx    = 0;
        menuIdx   = 0;
        resetState();
        frameFormat();
        jingleStart();
        jingleExtend();
        menuPitch();
        menuRestart();
        $display("tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== gameMusicTop.f ====
src/audioPkg.sv
src/menuTheme.sv
src/collisionEffect.sv
src/musicSequencer.sv
src/toneGenerator.sv
src/i2sSerializer.sv
src/gameMusicTop.sv
testbench/tbClock.sv
testbench/gameMusicTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= gameMusicTb
FILELIST  ?= gameMusicTop.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
